// File: px_tests.dat
// Columns: operation as ASCII hex (57 W, 52 R, 45 E, 53 S, 48 H, 41 A, 46 F), address, value
// W write, R read and compare, E read expecting err, S start, H wait halt, A AC, F awaria
0041 0000 0000  // AC clear after reset
0057 0040 1234  // Data words
0057 0041 0f0f
0057 0042 0101
0057 0051 dead
0057 0053 beef
0057 0010 1040  // lw 40
0057 0011 2041  // ad 41
0057 0012 2042  // ad 42
0057 0013 3050  // sw 50
0057 0014 0000  // hlt
0052 0040 1234  // Read back
0052 0012 2042
0053 0010 0000  // Sum program
0048 0000 0000
0041 0000 2244
0046 0000 0000
0052 0050 2244
0057 0020 4022  // jmp 22
0057 0021 3051  // sw 51, skipped
0057 0022 3052  // sw 52
0057 0023 0000  // hlt
0053 0020 0000  // Jump program
0048 0000 0000
0052 0051 dead
0052 0052 2244
0057 0050 0000  // Clear result, rerun with channel traffic
0053 0010 0000
0052 0041 0f0f
0052 0042 0101
0052 0011 2041
0052 0053 beef
0048 0000 0000
0041 0000 2244
0052 0050 2244
0045 0100 0000  // Past the memory
0045 8000 0000
0057 0030 1042  // lw 42
0057 0031 1300  // lw 300, nobody answers
0053 0030 0000
0048 0000 0000
0046 0000 0001
0041 0000 0101

// File: tb.f
px_pkg.sv
px_state.sv
strob_gen.sv
bus_arb.sv
sys_mem.sv
px_sys.sv
tb_clk.sv
tb_px.sv

// File: run.sh
#!/bin/sh
# Build and run the px_sys testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_px -f tb.f -o tb_px_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_px_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0

// File: tb_px.sv
`timescale 1ns/100ps

module tb_px
	import px_pkg::*;
();

	localparam int max_ops = 64;        // Operations the test file may hold
	localparam int line_cycles = 400;   // Watchdog budget per operation
	localparam int access_limit = 100;  // Channel wait before giving up
	localparam int halt_limit = 300;    // Program run before giving up

	logic              got;
	logic              clo_;
	logic              start;
	logic [word_w-1:0] start_addr;
	logic              ch_req;
	logic              ch_we;
	logic [word_w-1:0] ch_addr;
	logic [word_w-1:0] ch_wdata;
	wire  [word_w-1:0] ch_rdata;
	wire               ch_ok;
	wire               ch_err;
	wire  [word_w-1:0] ac;
	wire  [word_w-1:0] ic;
	wire               halt;
	wire               awaria;

	logic [word_w-1:0] tests [3*max_ops];  // Op, address, value per line
	int                n_ops;              // Set once after loading
	int                cur_line;           // For error lines
	logic [31:0]       lfsr;               // Idle gap source

	tb_clk i_tb_clk (
		.got  (got),
		.clo_ (clo_)
	);

	px_sys i_px_sys (
		.got        (got),
		.clo_       (clo_),
		.start      (start),
		.start_addr (start_addr),
		.ch_req     (ch_req),
		.ch_we      (ch_we),
		.ch_addr    (ch_addr),
		.ch_wdata   (ch_wdata),
		.ch_rdata   (ch_rdata),
		.ch_ok      (ch_ok),
		.ch_err     (ch_err),
		.ac         (ac),
		.ic         (ic),
		.halt       (halt),
		.awaria     (awaria)
	);

	// Right shift Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic end_with_failure;
		$display(">>> FAIL");
		$fatal(1, "tb_px stopped on the first error");
	endtask

	task automatic check_value(input string what, input logic [word_w-1:0] seen,
			input logic [word_w-1:0] exp);
		assert (seen === exp)
		else begin
			$display("[ERROR] %0d ns: line %0d, %s is %h, expected %h",
				$time, cur_line, what, seen, exp);
			end_with_failure();
		end
	endtask

	// Two LFSR bits give 0 to 3 idle cycles
	task automatic idle_gap;
		int n;
		n = 0;
		repeat (2) begin
			n = (n << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
		repeat (n) @(posedge got);
	endtask

	// One channel access, req held until ok or err, dropped the cycle after
	task automatic channel_access(input logic we, input logic [word_w-1:0] addr,
			input logic [word_w-1:0] wdata, output logic [word_w-1:0] rdata,
			output logic err_seen);
		int   waited;
		logic done;
		waited = 0;
		done = 1'b0;
		err_seen = 1'b0;
		rdata = '0;
		@(posedge got);
		ch_req <= 1'b1;
		ch_we <= we;
		ch_addr <= addr;
		ch_wdata <= wdata;
		while (!done && waited < access_limit) begin
			@(negedge got);                   // Answer is stable mid cycle
			if (ch_ok || ch_err) begin
				done = 1'b1;
				err_seen = ch_err;
				rdata = ch_rdata;
			end
			waited++;
		end
		assert (done)
		else begin
			$display("Channel access to %h got neither ok nor err on line %0d", addr, cur_line);
			end_with_failure();
		end
		@(posedge got);
		ch_req <= 1'b0;
		ch_we <= 1'b0;
	endtask

	task automatic pulse_start(input logic [word_w-1:0] addr);
		@(posedge got);
		start <= 1'b1;
		start_addr <= addr;
		@(posedge got);
		start <= 1'b0;                       // One cycle pulse
	endtask

	task automatic wait_halt;
		int waited;
		waited = 0;
		do begin
			@(negedge got);
			waited++;
		end while (!halt && waited < halt_limit);
		assert (halt)
		else begin
			$display("CPU did not halt within %0d cycles on line %0d", halt_limit, cur_line);
			end_with_failure();
		end
	endtask

	initial begin
		logic [word_w-1:0] op;
		logic [word_w-1:0] addr;
		logic [word_w-1:0] value;
		logic [word_w-1:0] rdata;
		logic              err_seen;
		int                count;
		start = 1'b0;
		start_addr = '0;
		ch_req = 1'b0;
		ch_we = 1'b0;
		ch_addr = '0;
		ch_wdata = '0;
		cur_line = 0;
		lfsr = 32'h162c_3eb1;
		for (int i = 0; i < 3 * max_ops; i++)
			tests[i] = '0;                   // Zero op marks the end
		$readmemh("px_tests.dat", tests);
		count = 0;
		while (count < max_ops && tests[3 * count] != '0)
			count++;
		n_ops = count;
		assert (count > 0)
		else begin
			$display("No operations found in px_tests.dat");
			end_with_failure();
		end
		wait (clo_ === 1'b1);
		@(posedge got);
		for (int k = 0; k < n_ops; k++) begin
			cur_line = k + 1;
			op = tests[3 * k];
			addr = tests[3 * k + 1];
			value = tests[3 * k + 2];
			case (op[7:0])
				"W": begin
					channel_access(1'b1, addr, value, rdata, err_seen);
					check_value("write err", word_w'(err_seen), '0);
					idle_gap();
				end
				"R": begin
					channel_access(1'b0, addr, '0, rdata, err_seen);
					check_value("read err", word_w'(err_seen), '0);
					check_value("read data", rdata, value);
					idle_gap();
				end
				"E": begin
					channel_access(1'b0, addr, '0, rdata, err_seen);
					check_value("read err", word_w'(err_seen), word_w'(1));
					idle_gap();
				end
				"S": begin
					pulse_start(addr);
					@(negedge got);
					check_value("IC", ic, addr);  // Loaded by the start pulse
				end
				"H": wait_halt();
				"A": begin
					@(negedge got);
					check_value("AC", ac, value);
				end
				"F": begin
					@(negedge got);
					check_value("awaria", word_w'(awaria), value);
				end
				default: begin
					$display("Unknown operation %h on line %0d of px_tests.dat", op, cur_line);
					end_with_failure();
				end
			endcase
		end
		$display(">>> PASS");
		$finish;
	end

	// Ends a run that stalls anywhere
	initial begin
		wait (n_ops > 0);
		repeat ((n_ops + 1) * line_cycles) @(posedge got);
		$display("Watchdog expired after %0d cycles, the tests did not finish",
			(n_ops + 1) * line_cycles);
		end_with_failure();
	end

endmodule

// File: tb_clk.sv
`timescale 1ns/100ps

module tb_clk (
	output logic got,   // System clock, 20 ns period
	output logic clo_   // General clear, low at power up
);

	localparam int half_period = 10;   // ns
	localparam int reset_cycles = 8;   // Clear held for this many edges

	initial begin
		got = 1'b0;
		forever #half_period got = ~got;
	end

	initial begin
		clo_ = 1'b0;
		repeat (reset_cycles) @(posedge got);
		clo_ <= 1'b1;                    // Release on a rising edge
	end

endmodule

// File: px_sys.sv
`timescale 1ns/100ps

module px_sys
	import px_pkg::*;
(
	input  logic              got,         // System clock
	input  logic              clo_,        // General clear
	input  logic              start,       // Start pulse
	input  logic [word_w-1:0] start_addr,  // Program entry
	input  logic              ch_req,      // Channel port
	input  logic              ch_we,
	input  logic [word_w-1:0] ch_addr,
	input  logic [word_w-1:0] ch_wdata,
	output logic [word_w-1:0] ch_rdata,
	output logic              ch_ok,
	output logic              ch_err,
	output logic [word_w-1:0] ac,          // Accumulator
	output logic [word_w-1:0] ic,          // Instruction counter
	output logic              halt,        // CPU stopped
	output logic              awaria       // Bus failure
);

	logic [st_n-1:0]   st_flags;   // State control to strobes
	logic              bus_need;
	logic              strob1;
	logic              strob2;
	logic              step;
	logic              cpu_req;    // CPU master port
	logic              cpu_we;
	logic [word_w-1:0] cpu_addr;
	logic [word_w-1:0] cpu_wdata;
	logic [word_w-1:0] cpu_rdata;
	logic              cpu_ok;
	logic              cpu_err;
	logic              mem_sel;    // Arbiter to memory
	logic              mem_we;
	logic [word_w-1:0] mem_addr;
	logic [word_w-1:0] mem_wdata;
	logic [word_w-1:0] mem_rdata;
	logic              mem_ok;

	px_state i_px_state (
		.got        (got),
		.clo_       (clo_),
		.start      (start),
		.start_addr (start_addr),
		.step       (step),
		.strob1     (strob1),
		.strob2     (strob2),
		.cpu_rdata  (cpu_rdata),
		.cpu_err    (cpu_err),
		.bus_need   (bus_need),
		.cpu_we     (cpu_we),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.st_flags   (st_flags),
		.ac         (ac),
		.ic         (ic),
		.halt       (halt),
		.awaria     (awaria)
	);

	strob_gen i_strob_gen (
		.got      (got),
		.clo_     (clo_),
		.st_flags (st_flags),
		.bus_need (bus_need),
		.cpu_ok   (cpu_ok),
		.cpu_err  (cpu_err),
		.strob1   (strob1),
		.strob2   (strob2),
		.step     (step),
		.cpu_req  (cpu_req)
	);

	bus_arb i_bus_arb (
		.got       (got),
		.clo_      (clo_),
		.ch_req    (ch_req),
		.ch_we     (ch_we),
		.ch_addr   (ch_addr),
		.ch_wdata  (ch_wdata),
		.cpu_req   (cpu_req),
		.cpu_we    (cpu_we),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.mem_rdata (mem_rdata),
		.mem_ok    (mem_ok),
		.ch_rdata  (ch_rdata),
		.ch_ok     (ch_ok),
		.ch_err    (ch_err),
		.cpu_rdata (cpu_rdata),
		.cpu_ok    (cpu_ok),
		.cpu_err   (cpu_err),
		.mem_sel   (mem_sel),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata)
	);

	sys_mem i_sys_mem (
		.got   (got),
		.clo_  (clo_),
		.sel   (mem_sel),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (mem_rdata),
		.ok    (mem_ok)
	);

endmodule

// File: sys_mem.sv
`timescale 1ns/100ps

module sys_mem
	import px_pkg::*;
(
	input  logic              got,    // System clock
	input  logic              clo_,   // General clear
	input  logic              sel,    // Access request
	input  logic              we,     // Write when set
	input  logic [word_w-1:0] addr,
	input  logic [word_w-1:0] wdata,
	output logic [word_w-1:0] rdata,  // Held until the next read
	output logic              ok      // Answer, one cycle after sel
);

	logic [word_w-1:0] mem [mem_words];  // Storage array

	wire hit = sel && (addr < mem_words);  // Out of range stays silent

	always_ff @(posedge got) begin
		if (hit) begin
			if (we)
				mem[addr[mem_aw-1:0]] <= wdata;
			else
				rdata <= mem[addr[mem_aw-1:0]];
		end
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_)
			ok <= 1'b0;
		else
			ok <= hit;
	end

endmodule

// File: bus_arb.sv
`timescale 1ns/100ps

module bus_arb
	import px_pkg::*;
(
	input  logic              got,        // System clock
	input  logic              clo_,       // General clear
	input  logic              ch_req,     // Channel request
	input  logic              ch_we,
	input  logic [word_w-1:0] ch_addr,
	input  logic [word_w-1:0] ch_wdata,
	input  logic              cpu_req,    // CPU request
	input  logic              cpu_we,
	input  logic [word_w-1:0] cpu_addr,
	input  logic [word_w-1:0] cpu_wdata,
	input  logic [word_w-1:0] mem_rdata,  // Memory answer
	input  logic              mem_ok,
	output logic [word_w-1:0] ch_rdata,
	output logic              ch_ok,
	output logic              ch_err,
	output logic [word_w-1:0] cpu_rdata,
	output logic              cpu_ok,
	output logic              cpu_err,
	output logic              mem_sel,    // Slave select
	output logic              mem_we,
	output logic [word_w-1:0] mem_addr,
	output logic [word_w-1:0] mem_wdata
);

	logic               gnt_ch;     // Channel holds the bus
	logic               gnt_cpu;    // CPU holds the bus
	logic [alarm_w-1:0] alarm_cnt;  // Cycles since grant

	wire busy = gnt_ch | gnt_cpu;
	wire own_ch = gnt_ch | (!busy && ch_req);                // Channel wins ties
	wire own_cpu = gnt_cpu | (!busy && !ch_req && cpu_req);
	wire timeout = busy && !mem_ok && (alarm_cnt == alarm_w'(alarm_ticks - 1)); // Alarm

	// Free bus grants the same cycle
	assign mem_sel = (own_ch | own_cpu) & ~mem_ok & ~timeout;
	assign mem_we = own_ch ? ch_we : cpu_we;
	assign mem_addr = own_ch ? ch_addr : cpu_addr;
	assign mem_wdata = own_ch ? ch_wdata : cpu_wdata;

	// Memory holds its read word, both masters see it
	assign ch_rdata = mem_rdata;
	assign cpu_rdata = mem_rdata;
	assign ch_ok = gnt_ch & mem_ok;
	assign cpu_ok = gnt_cpu & mem_ok;
	assign ch_err = gnt_ch & timeout;
	assign cpu_err = gnt_cpu & timeout;

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			gnt_ch <= 1'b0;
			gnt_cpu <= 1'b0;
			alarm_cnt <= '0;
		end else if (mem_ok || timeout) begin
			gnt_ch <= 1'b0;                  // Free from the next cycle
			gnt_cpu <= 1'b0;
			alarm_cnt <= '0;
		end else begin
			gnt_ch <= own_ch;
			gnt_cpu <= own_cpu;
			alarm_cnt <= busy ? alarm_cnt + 1'b1 : '0;
		end
	end

	// One answer per cycle, to one master alone
	a_one_answer: assert property (@(posedge got) disable iff (!clo_)
		$onehot0({ch_ok, ch_err, cpu_ok, cpu_err}))
		else $error("bus_arb: more than one answer given in a cycle");

	// Slave answers only a selected access
	a_ok_after_sel: assert property (@(posedge got) disable iff (!clo_)
		mem_ok |-> $past(mem_sel))
		else $error("bus_arb: ok without a preceding sel");

endmodule

// File: strob_gen.sv
`timescale 1ns/100ps

module strob_gen
	import px_pkg::*;
(
	input  logic            got,       // System clock
	input  logic            clo_,      // General clear
	input  logic [st_n-1:0] st_flags,  // Active state
	input  logic            bus_need,  // State needs a bus access
	input  logic            cpu_ok,    // Access done
	input  logic            cpu_err,   // Access timed out
	output logic            strob1,    // First strobe
	output logic            strob2,    // Second strobe
	output logic            step,      // Advance to next state
	output logic            cpu_req    // Bus request
);

	typedef enum logic [2:0] {ph_idle, ph_s1, ph_bus, ph_s2, ph_step} phase_t;

	phase_t            ph;    // Position in the state cycle
	logic [tick_w-1:0] tick;  // Ticks spent in a strobe phase

	wire any_st = |st_flags;

	assign strob1 = (ph == ph_s1) && any_st;   // Quiet after the last step
	assign strob2 = (ph == ph_s2);
	assign step = (ph == ph_step);
	assign cpu_req = (ph == ph_bus);           // Request only while waiting

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			ph <= ph_idle;
			tick <= '0;
		end else begin
			case (ph)
				ph_idle: if (any_st) begin
					ph <= ph_s1;
					tick <= '0;
				end
				ph_s1: if (!any_st) begin
					ph <= ph_idle;               // Halted on previous step
				end else if (tick == tick_w'(strob1_ticks - 1)) begin
					ph <= bus_need ? ph_bus : ph_s2;
					tick <= '0;
				end else begin
					tick <= tick + 1'b1;
				end
				ph_bus: if (cpu_ok || cpu_err) begin
					ph <= ph_s2;                 // Wait length set by the bus
					tick <= '0;
				end
				ph_s2: if (tick == tick_w'(strob2_ticks - 1))
					ph <= ph_step;
				else
					tick <= tick + 1'b1;
				ph_step: begin                   // Straight into next cycle
					ph <= ph_s1;
					tick <= '0;
				end
				default: ph <= ph_idle;
			endcase
		end
	end

	// Handshake, request held until the arbiter answers
	a_req_hold: assert property (@(posedge got) disable iff (!clo_)
		$fell(cpu_req) |-> $past(cpu_ok || cpu_err))
		else $error("strob_gen: cpu_req dropped before ok or err");

endmodule

// File: px_state.sv
`timescale 1ns/100ps

module px_state
	import px_pkg::*;
(
	input  logic              got,         // System clock
	input  logic              clo_,        // General clear
	input  logic              start,       // Start pulse
	input  logic [word_w-1:0] start_addr,  // First instruction address
	input  logic              step,        // End of state cycle
	input  logic              strob1,      // Start of state cycle
	input  logic              strob2,      // Data latch strobe
	input  logic [word_w-1:0] cpu_rdata,   // Read data from the bus
	input  logic              cpu_err,     // No memory answered
	output logic              bus_need,    // Current state uses the bus
	output logic              cpu_we,      // Bus write
	output logic [word_w-1:0] cpu_addr,    // Bus address
	output logic [word_w-1:0] cpu_wdata,   // Bus write data
	output logic [st_n-1:0]   st_flags,    // P1, WR, WW flip-flops
	output logic [word_w-1:0] ac,          // Accumulator
	output logic [word_w-1:0] ic,          // Instruction counter
	output logic              halt,        // CPU stopped
	output logic              awaria       // Bus failure flag
);

	logic              running;   // Between start and halt
	logic              bus_fail;  // err seen in this cycle
	logic [word_w-1:0] ir;        // Instruction register
	logic [st_n-1:0]   nxt_st;    // State after P1

	wire [op_w-1:0]   op = ir[word_w-1 -: op_w];                         // Opcode field
	wire [word_w-1:0] arg = {{op_w{1'b0}}, ir[word_w-op_w-1:0]};         // Argument address
	wire stop_op = (op == op_hlt) || !(op inside {op_lw, op_ad, op_sw, op_jmp}); // Halt codes

	// Every state talks to memory
	assign bus_need = |st_flags;
	assign cpu_we = st_flags[st_ww];                    // Only WW writes
	assign cpu_addr = st_flags[st_p1] ? ic : arg;       // Fetch at IC, operand at arg
	assign cpu_wdata = ac;

	// Next state after a fetch
	always_comb begin
		case (op)
			op_lw, op_ad: nxt_st = st_n'(1) << st_wr;   // Operand read
			op_sw:        nxt_st = st_n'(1) << st_ww;   // Operand write
			default:      nxt_st = st_n'(1) << st_p1;   // jmp fetches again
		endcase
	end

	// Instruction latch, fetched word on strob2 of P1
	always_ff @(posedge got) begin
		if (strob2 && st_flags[st_p1] && !bus_fail)
			ir <= cpu_rdata;
	end

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			st_flags <= '0;
			running <= 1'b0;
			bus_fail <= 1'b0;
			halt <= 1'b0;
			awaria <= 1'b0;
			ic <= '0;
			ac <= '0;
		end else begin
			if (start && !running) begin       // Load IC, P1 follows next cycle
				ic <= start_addr;
				running <= 1'b1;
				halt <= 1'b0;
				awaria <= 1'b0;
			end else if (running && st_flags == '0) begin
				st_flags <= st_n'(1) << st_p1;   // Enter first fetch
			end

			if (strob1)
				bus_fail <= 1'b0;                // New cycle, forget old err
			if (cpu_err)
				bus_fail <= 1'b1;                // Held until step

			// Operand into AC, skipped when the read failed
			if (strob2 && st_flags[st_wr] && !bus_fail)
				ac <= (op == op_ad) ? ac + cpu_rdata : cpu_rdata;

			if (step) begin
				if (bus_fail) begin               // Alarm stops the machine
					st_flags <= '0;
					running <= 1'b0;
					halt <= 1'b1;
					awaria <= 1'b1;
				end else if (st_flags[st_p1]) begin
					if (stop_op) begin
						ic <= ic + 1'b1;
						st_flags <= '0;
						running <= 1'b0;
						halt <= 1'b1;
					end else begin
						ic <= (op == op_jmp) ? arg : ic + 1'b1;
						st_flags <= nxt_st;
					end
				end else begin
					st_flags <= st_n'(1) << st_p1; // WR and WW return to fetch
				end
			end
		end
	end

	// Next-state logic must never leave two cycles active
	a_one_state: assert property (@(posedge got) disable iff (!clo_)
		$onehot0(st_flags))
		else $error("px_state: more than one state flag set");

endmodule

// File: px_pkg.sv
package px_pkg;

	// Word and memory geometry
	localparam int word_w = 16;                 // Data word and address width
	localparam int op_w = 4;                    // Opcode field in the top bits
	localparam int mem_words = 256;             // Words present in memory
	localparam int mem_aw = $clog2(mem_words);  // Index bits into the array

	// Instruction set, opcode in bits 15..12, argument address in 11..0
	localparam logic [op_w-1:0] op_hlt = 4'h0;  // Stop, also any unknown code
	localparam logic [op_w-1:0] op_lw = 4'h1;   // AC = mem[arg]
	localparam logic [op_w-1:0] op_ad = 4'h2;   // AC = AC + mem[arg]
	localparam logic [op_w-1:0] op_sw = 4'h3;   // mem[arg] = AC
	localparam logic [op_w-1:0] op_jmp = 4'h4;  // IC = arg

	// Cycle state flip-flops, one bit each in st_flags
	localparam int st_n = 3;    // Number of state flags
	localparam int st_p1 = 0;   // Instruction fetch
	localparam int st_wr = 1;   // Operand read
	localparam int st_ww = 2;   // Operand write

	// Bus and strobe timing in got cycles
	localparam int alarm_ticks = 16;                 // Wait for ok before alarm
	localparam int alarm_w = $clog2(alarm_ticks);    // Alarm counter width
	localparam int strob1_ticks = 1;                 // First strobe phase
	localparam int strob2_ticks = 1;                 // Second strobe phase
	localparam int tick_w = 4;                       // Strobe tick counter width

endpackage
